/* verification/heap_stim.txt */
# action array index in out error, all hex, one line per cycle; out "-" is not compared
# actions: 0 idle 1 clearAll 2 write 3 read 4 size 5 push 6 pop 7 index 8 less 9 greater
#          a alloc b free c add d subtract e orOp f xorOp 10 andOp
# errors:  0 none 1 notAllocated 2 outOfBounds 3 full 4 empty 5 outOfMemory
# allocation and free stack
a 0 0 0000 0000 0
a 0 0 0000 0001 0
a 0 0 0000 0002 0
a 0 0 0000 0003 0
a 0 0 0000 -    5
b 2 0 0000 -    0
b 1 0 0000 -    0
a 0 0 0000 0001 0
a 0 0 0000 0002 0
b 1 0 0000 -    0
b 1 0 0000 -    1
0 0 0 0000 -    1
# write, read and size on array 0
2 0 0 000a 000a 0
2 0 1 0014 0014 0
2 0 2 001e 001e 0
4 0 0 0000 0003 0
3 0 0 0000 000a 0
3 0 1 0000 0014 0
3 0 2 0000 001e 0
3 0 5 0000 -    2
2 1 0 0063 -    1
# search on array 0
7 0 0 001e 0003 0
7 0 0 0014 0002 0
7 0 0 000a 0001 0
7 0 0 000f 0000 0
8 0 0 0023 0003 0
8 0 0 0019 0002 0
8 0 0 000f 0001 0
8 0 0 0005 0000 0
9 0 0 0023 0000 0
9 0 0 0019 0001 0
9 0 0 000f 0002 0
9 0 0 0005 0003 0
# push and pop on array 3
5 3 0 0011 -    0
5 3 0 0022 -    0
5 3 0 0033 -    0
5 3 0 0044 -    0
5 3 0 0055 -    0
5 3 0 0066 -    0
5 3 0 0077 -    0
5 3 0 0088 -    0
5 3 0 0099 -    3
6 3 0 0000 0088 0
6 3 0 0000 0077 0
6 3 0 0000 0066 0
6 3 0 0000 0055 0
6 3 0 0000 0044 0
6 3 0 0000 0033 0
6 3 0 0000 0022 0
6 3 0 0000 0011 0
6 3 0 0000 -    4
# element arithmetic, then a refused add on empty array 3
c 0 0 ffff 0009 0
3 0 0 0000 0009 0
d 0 1 0020 fff4 0
3 0 1 0000 fff4 0
e 0 2 0101 011f 0
f 0 2 ffff fee0 0
10 0 2 0ff0 0ee0 0
3 0 2 0000 0ee0 0
c 3 2 0001 -    2
2 3 3 0005 0005 0
3 3 2 0000 0033 0
# clearAll
1 0 0 0000 -    0
3 0 0 0000 -    1
a 0 0 0000 0000 0

/* sim.f */
+incdir+logic
logic/heapPkg.sv
logic/heapDirectory.sv
logic/arrayStore.sv
logic/arraySearch.sv
logic/heapMemory.sv
verification/heap_assertions.sv
verification/heapChecker.sv
verification/heapMemory_tb.sv

/* verification/heapMemory_tb.sv */
/*
  Testbench of the array heap. Reads one action per line from the stim
  file, drives it on the falling edge and hands the expected result of
  that line to the checker once the DUT has sampled it.
*/

`timescale 1ns/1ps
`default_nettype none

module heapMemoryTb
  import heapPkg::*;
();

  localparam int resetCycles = 8;
  localparam int stimLines   = 65;                              // Data lines in the stim file
  localparam int cycleLimit  = stimLines + resetCycles + 20;

  logic        clock;
  logic        resetN;
  heapAction_t action;
  arrayNum_t   array;
  elemIndex_t  index;
  heapData_t   in;
  heapData_t   out;
  heapError_t  error;
  logic        checkEn;                                         // Expected fields are valid
  logic        expCare;                                         // Compare out too
  heapData_t   expOut;
  heapError_t  expError;
  int          cycleCount;
  int          lineCount;                                       // Data lines driven
  int          fd;

  heapMemory i_heapMemory (
    .clock  (clock),
    .resetN (resetN),
    .action (action),
    .array  (array),
    .index  (index),
    .in     (in),
    .out    (out),
    .error  (error)
  );

  heapChecker i_heapChecker (
    .clock    (clock),
    .checkEn  (checkEn),
    .action   (action),
    .expCare  (expCare),
    .expOut   (expOut),
    .expError (expError),
    .out      (out),
    .error    (error)
  );

  bind heapMemory heapAssertions i_heapAssertions (
    .clock  (clock),
    .resetN (resetN),
    .action (action),
    .out    (out),
    .error  (error)
  );

  // --------------------
  // Clock and run limit
  initial begin
    clock = 1'b0;
    forever begin
      #2 clock = ~clock;                                        // 4 ns period
    end
  end

  always @(posedge clock) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      $display("Timeout after %0d cycles, stimulus did not finish", cycleCount);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // --------------------
  // Stimulus
  task automatic driveStimulus();
    logic [8*96-1:0] lineBuf;
    logic [8*8-1:0]  outTok;                                    // Hex value or dash
    logic [7:0]      actVal;
    logic [7:0]      arrVal;
    logic [7:0]      idxVal;
    logic [15:0]     inVal;
    logic [15:0]     outVal;
    logic [7:0]      errVal;
    int              status;
    int              fields;
    while (!$feof(fd)) begin
      lineBuf = '0;
      status  = $fgets(lineBuf, fd);
      fields  = $sscanf(lineBuf, "%h %h %h %h %s %h",
                        actVal, arrVal, idxVal, inVal, outTok, errVal);
      if (status > 0 && fields == 6) begin                      // Comment lines give no fields
        outVal = '0;
        if (outTok != "-") begin
          status = $sscanf(outTok, "%h", outVal);
        end
        @(negedge clock);
        action = heapAction_t'(actVal[4:0]);
        array  = arrayNum_t'(arrVal);
        index  = elemIndex_t'(idxVal);
        in     = inVal;
        @(posedge clock);                                       // DUT has sampled the line
        expCare   = outTok != "-";
        expOut    = outVal;
        expError  = heapError_t'(errVal[2:0]);
        checkEn   = 1'b1;
        lineCount = lineCount + 1;
      end
    end
    @(negedge clock);                                           // Last line checked here
    action = idle;
    @(posedge clock);
    checkEn = 1'b0;
  endtask

  initial begin
    resetN     = 1'b0;
    action     = idle;
    array      = '0;
    index      = '0;
    in         = '0;
    checkEn    = 1'b0;
    expCare    = 1'b0;
    expOut     = '0;
    expError   = none;
    cycleCount = 0;
    lineCount  = 0;
    fd = $fopen("verification/heap_stim.txt", "r");
    if (fd == 0) begin
      $display("Stimulus file verification/heap_stim.txt could not be opened");
    end else begin
      repeat (resetCycles) @(negedge clock);
      resetN = 1'b1;
      driveStimulus();
      $fclose(fd);
      if (lineCount != stimLines) begin
        $display("Read %0d stimulus lines but expected %0d", lineCount, stimLines);
      end
    end
    $display("Lines: %0d, checks: %0d, errors: %0d, assertion failures: %0d",
             lineCount, i_heapChecker.checkCount, i_heapChecker.errorCount,
             i_heapMemory.i_heapAssertions.failCount);
    if (fd != 0 && lineCount == stimLines && i_heapChecker.errorCount == 0 &&
        i_heapMemory.i_heapAssertions.failCount == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verification/heapChecker.sv */
/*
  Compares out and error of the heap with the expected fields of the
  line the DUT sampled last. Samples on the falling edge, where the
  registered outputs are stable, and counts every mismatch.
*/

`timescale 1ns/1ps
`default_nettype none

module heapChecker
  import heapPkg::*;
(
  input wire              clock,
  input wire              checkEn,    // Expected fields belong to a driven line
  input wire heapAction_t action,     // DUT input, for messages
  input wire              expCare,    // Out is compared
  input wire heapData_t   expOut,
  input wire heapError_t  expError,
  input wire heapData_t   out,
  input wire heapError_t  error
);

  heapAction_t lastAction;            // Action behind the current outputs
  int          checkCount;
  int          errorCount;

  initial begin
    checkCount = 0;
    errorCount = 0;
  end

  always @(posedge clock) begin
    lastAction <= action;
  end

  // --------------------
  // Compare
  always @(negedge clock) begin
    if (checkEn) begin
      checkCount = checkCount + 1;
      if (error !== expError) begin
        errorCount = errorCount + 1;
        $display("FAIL %0t: %s gave error %0d, expected %0d",
                 $time, lastAction.name(), error, expError);
      end
      if (expCare && out !== expOut) begin      // Dash lines skip this
        errorCount = errorCount + 1;
        $display("FAIL %0t: %s gave out %h, expected %h",
                 $time, lastAction.name(), out, expOut);
      end
    end
  end

endmodule

`default_nettype wire

/* verification/heap_assertions.sv */
/*
  Concurrent checks on the heap top level, bound into heapMemory by the
  testbench. Covers reset values and the hold of both outputs on idle.
*/

`timescale 1ns/1ps
`default_nettype none

module heapAssertions
  import heapPkg::*;
(
  input wire              clock,
  input wire              resetN,
  input wire heapAction_t action,
  input wire heapData_t   out,
  input wire heapError_t  error
);

  int failCount;                      // Failed assertions, read by the testbench

  initial begin
    failCount = 0;
  end

  // --------------------
  // Reset values
  resetOutputs: assert property (@(posedge clock) !resetN |-> out == '0 && error == none)
    else begin
      failCount = failCount + 1;
      $error("out or error not cleared while reset is low");
    end

  // --------------------
  // Idle holds both outputs
  idleHoldsError: assert property (@(posedge clock) disable iff (!resetN)
      action == idle |=> $stable(error))
    else begin
      failCount = failCount + 1;
      $error("error changed after an idle action");
    end

  idleHoldsOut: assert property (@(posedge clock) disable iff (!resetN)
      action == idle |=> $stable(out))
    else begin
      failCount = failCount + 1;
      $error("out changed after an idle action");
    end

endmodule

`default_nettype wire

/* logic/heapMemory.sv */
/*
  Top level of the array heap. Takes one action per clock cycle, checks
  it in the directory, runs it on the store and the search unit, and
  registers the result on out and the outcome on error.
*/

`timescale 1ns/1ps
`default_nettype none

module heapMemory
  import heapPkg::*;
(
  input  wire              clock,
  input  wire              resetN,
  input  wire heapAction_t action,
  input  wire arrayNum_t   array,
  input  wire elemIndex_t  index,
  input  wire heapData_t   in,
  output heapData_t        out,
  output heapError_t       error
);

  logic       allocReq;
  logic       freeReq;
  logic       clearReq;
  logic       growReq;
  logic       popReq;
  logic       needRead;
  logic       isArith;          // Read-modify-write actions
  logic       greaterMode;
  logic       accepted;         // Directory found no error
  logic       writeEn;
  logic       loadsOut;         // Action produces a value on out
  heapError_t accessError;
  arrayNum_t  allocArray;
  arraySize_t curSize;
  elemIndex_t pushIndex;
  elemIndex_t elemIdx;
  heapData_t  elemValue;
  heapData_t  newValue;
  heapData_t  result;
  arrayRow_t  row;
  arraySize_t matchIndex;
  arraySize_t lessCount;

  // --------------------
  // Action decode
  assign isArith     = action inside {add, subtract, orOp, xorOp, andOp};
  assign allocReq    = action == alloc;
  assign freeReq     = action == free;
  assign clearReq    = action == clearAll;
  assign growReq     = action inside {write, push};
  assign popReq      = action inside {pop, push};         // Push raises both stack strobes
  assign needRead    = action == read || isArith;
  assign greaterMode = action == greater;

  assign accepted = accessError == none;
  assign writeEn  = accepted && (growReq || isArith);     // Only legal actions touch elements
  assign elemIdx  = (action inside {push, pop}) ? pushIndex : index;

  heapDirectory i_heapDirectory (
    .clock       (clock),
    .resetN      (resetN),
    .array       (array),
    .index       (index),
    .allocReq    (allocReq),
    .freeReq     (freeReq),
    .clearReq    (clearReq),
    .growReq     (growReq),
    .popReq      (popReq),
    .needRead    (needRead),
    .accessError (accessError),
    .allocArray  (allocArray),
    .curSize     (curSize),
    .pushIndex   (pushIndex)
  );

  arrayStore i_arrayStore (
    .clock     (clock),
    .writeEn   (writeEn),
    .arithSel  (action),
    .array     (array),
    .elemIdx   (elemIdx),
    .in        (in),
    .elemValue (elemValue),
    .newValue  (newValue),
    .row       (row)
  );

  arraySearch i_arraySearch (
    .row         (row),
    .curSize     (curSize),
    .key         (in),
    .greaterMode (greaterMode),
    .matchIndex  (matchIndex),
    .lessCount   (lessCount)
  );

  // --------------------
  // Result select
  always_comb begin
    loadsOut = 1'b1;
    case (action)
      write, add, subtract, orOp, xorOp, andOp: result = newValue;
      read, pop:                                 result = elemValue;
      size:                                      result = heapData_t'(curSize);
      heapPkg::index:                            result = heapData_t'(matchIndex);  // Port shadows literal
      less, greater:                             result = heapData_t'(lessCount);
      alloc:                                     result = heapData_t'(allocArray);
      default: begin                                                                // Push, free, clear, idle
        result   = elemValue;
        loadsOut = 1'b0;
      end
    endcase
  end

  // --------------------
  // Output registers
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      out   <= '0;
      error <= none;
    end else if (action != idle) begin
      error <= accessError;                               // Every real action reports
      if (loadsOut && accepted) begin
        out <= result;                                    // Failed actions keep old out
      end
    end
  end

endmodule

`default_nettype wire

/* logic/arraySearch.sv */
/*
  Combinational search over the live part of one array. Gives the
  1-based position of the last element equal to key and the count of
  elements below key, or above key in greater mode.
*/

`timescale 1ns/1ps
`default_nettype none

`include "heap_config.svh"

module arraySearch
  import heapPkg::*;
(
  input  wire arrayRow_t  row,          // All elements of one array
  input  wire arraySize_t curSize,      // Elements at and above this are dead
  input  wire heapData_t  key,
  input  wire             greaterMode,  // Count above key instead of below
  output arraySize_t      matchIndex,   // 0 when nothing matches
  output arraySize_t      lessCount
);

  heapData_t                     elem [`HEAP_ARRAY_LENGTH];
  logic [`HEAP_ARRAY_LENGTH-1:0] live;      // Below curSize
  logic [`HEAP_ARRAY_LENGTH-1:0] hit;       // Live and equal to key
  logic [`HEAP_ARRAY_LENGTH-1:0] counted;   // Live and on the chosen side of key

  // --------------------
  // Per element compare
  for (genvar e = 0; e < `HEAP_ARRAY_LENGTH; e++) begin : gCompare
    assign elem[e]    = row[e*`HEAP_DATA_BITS +: `HEAP_DATA_BITS];
    assign live[e]    = e < curSize;
    assign hit[e]     = live[e] && elem[e] == key;
    assign counted[e] = live[e] && (greaterMode ? elem[e] > key : elem[e] < key);
  end

  // --------------------
  // Reduce
  always_comb begin
    matchIndex = '0;
    for (int i = 0; i < `HEAP_ARRAY_LENGTH; i++) begin
      if (hit[i]) begin
        matchIndex = arraySize_t'(i + 1);                  // Later hits win
      end
    end
  end

  always_comb begin
    lessCount = '0;
    for (int i = 0; i < `HEAP_ARRAY_LENGTH; i++) begin
      lessCount = lessCount + arraySize_t'(counted[i]);
    end
  end

endmodule

`default_nettype wire

/* logic/arrayStore.sv */
/*
  Element registers of all arrays, the element arithmetic unit and the
  read-out of one whole array for the search unit.
*/

`timescale 1ns/1ps
`default_nettype none

`include "heap_config.svh"

module arrayStore
  import heapPkg::*;
(
  input  wire              clock,
  input  wire              writeEn,     // Store newValue this edge
  input  wire heapAction_t arithSel,    // Picks the operation on the element
  input  wire arrayNum_t   array,
  input  wire elemIndex_t  elemIdx,     // User index or stack end slot
  input  wire heapData_t   in,          // Operand from user
  output heapData_t        elemValue,   // Element before the action
  output heapData_t        newValue,    // Element after the action
  output arrayRow_t        row          // Whole addressed array
);

  // --------------------
  // Element registers
  heapData_t elems [`HEAP_ARRAYS][`HEAP_ARRAY_LENGTH];   // Contents survive reset

  assign elemValue = elems[array][elemIdx];

  // --------------------
  // Element arithmetic
  always_comb begin
    case (arithSel)
      add: begin
        newValue = elemValue + in;                           // Wraps at 16 bits
      end
      subtract: begin
        newValue = elemValue - in;                           // Wraps below zero
      end
      orOp: begin
        newValue = elemValue | in;
      end
      xorOp: begin
        newValue = elemValue ^ in;
      end
      andOp: begin
        newValue = elemValue & in;
      end
      default: begin
        newValue = in;                                       // Write and push store in
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (writeEn) begin
      elems[array][elemIdx] <= newValue;
    end
  end

  // --------------------
  // Row read-out
  // Element e sits at bits e*16 and up
  for (genvar e = 0; e < `HEAP_ARRAY_LENGTH; e++) begin : gRow
    assign row[e*`HEAP_DATA_BITS +: `HEAP_DATA_BITS] = elems[array][e];
  end

endmodule

`default_nettype wire

/* logic/heapDirectory.sv */
/*
  Bookkeeping of the heap: live size and allocation flag of each array,
  the stack of freed arrays and the count of arrays ever handed out.
  Checks every access in the same cycle and steers the element store.
*/

`timescale 1ns/1ps
`default_nettype none

`include "heap_config.svh"

module heapDirectory
  import heapPkg::*;
(
  input  wire             clock,
  input  wire             resetN,
  input  wire arrayNum_t  array,        // Array addressed by the action
  input  wire elemIndex_t index,        // User index
  input  wire             allocReq,
  input  wire             freeReq,
  input  wire             clearReq,
  input  wire             growReq,      // Write or push
  input  wire             popReq,       // Pop, or push together with growReq
  input  wire             needRead,     // Action needs index < size
  output heapError_t      accessError,
  output arrayNum_t       allocArray,   // Array an alloc would hand out
  output arraySize_t      curSize,      // Size of addressed array
  output elemIndex_t      pushIndex     // Stack end slot for push or pop
);

  arraySize_t                sizes [`HEAP_ARRAYS];      // Live length per array
  logic [`HEAP_ARRAYS-1:0]   allocated;                 // Array in use
  arrayNum_t                 freeStack [`HEAP_ARRAYS];  // Freed arrays, last in first out
  logic [`HEAP_ARRAY_BITS:0] freeTop;                   // Entries on free stack
  logic [`HEAP_ARRAY_BITS:0] usedCount;                 // Arrays ever handed out
  arrayNum_t                 topSlot;                   // Newest free stack entry
  logic                      fromStack;                 // Alloc reuses a freed array
  logic                      pushReq;
  logic                      popOnly;
  logic                      writeReq;
  logic                      accept;                    // Action passes all checks

  // --------------------
  // Request decode
  assign pushReq  = growReq & popReq;   // Push raises both stack strobes
  assign writeReq = growReq & ~popReq;
  assign popOnly  = popReq & ~growReq;

  assign curSize   = sizes[array];
  assign topSlot   = arrayNum_t'(freeTop - 1'b1);
  assign fromStack = freeTop != '0;
  assign allocArray = fromStack ? freeStack[topSlot] : arrayNum_t'(usedCount);

  // Pop takes the last live element, push the first free one
  assign pushIndex = popOnly ? elemIndex_t'(curSize - 1'b1) : elemIndex_t'(curSize);

  // --------------------
  // Access checks
  always_comb begin
    if (clearReq) begin
      accessError = none;
    end else if (allocReq) begin
      if (fromStack || usedCount < `HEAP_ARRAYS) begin
        accessError = none;
      end else begin
        accessError = outOfMemory;                                 // Every array handed out
      end
    end else if (!allocated[array]) begin
      accessError = notAllocated;                                  // Also catches double free
    end else if (needRead && arraySize_t'(index) >= curSize) begin
      accessError = outOfBounds;
    end else if (pushReq && curSize == `HEAP_ARRAY_LENGTH) begin
      accessError = full;
    end else if (popOnly && curSize == '0) begin
      accessError = empty;
    end else begin
      accessError = none;
    end
  end

  assign accept = accessError == none;

  // --------------------
  // Directory registers
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      for (int i = 0; i < `HEAP_ARRAYS; i++) begin
        sizes[i] <= '0;
      end
      allocated <= '0;
      freeTop   <= '0;
      usedCount <= '0;
    end else if (accept) begin
      if (clearReq) begin                                          // Same state as reset
        for (int i = 0; i < `HEAP_ARRAYS; i++) begin
          sizes[i] <= '0;
        end
        allocated <= '0;
        freeTop   <= '0;
        usedCount <= '0;
      end else if (allocReq) begin
        allocated[allocArray] <= 1'b1;
        sizes[allocArray]     <= '0;                               // New array starts empty
        if (fromStack) begin
          freeTop <= freeTop - 1'b1;
        end else begin
          usedCount <= usedCount + 1'b1;
        end
      end else if (freeReq) begin
        allocated[array] <= 1'b0;
        freeTop          <= freeTop + 1'b1;
      end else if (pushReq) begin
        sizes[array] <= curSize + 1'b1;
      end else if (popOnly) begin
        sizes[array] <= curSize - 1'b1;
      end else if (writeReq && arraySize_t'(index) >= curSize) begin
        sizes[array] <= arraySize_t'(index) + 1'b1;                // Write past end grows array
      end
    end
  end

  // Free stack entries, valid below freeTop only
  always_ff @(posedge clock) begin
    if (freeReq && accept) begin
      freeStack[freeTop[`HEAP_ARRAY_BITS-1:0]] <= array;
    end
  end

endmodule

`default_nettype wire

/* logic/heapPkg.sv */
/*
  Shared types of the array heap: width typedefs, the action codes
  driven by the user and the error codes returned with every action.
*/

`default_nettype none

`include "heap_config.svh"

package heapPkg;

  // --------------------
  // Widths with a meaning
  typedef logic [`HEAP_ARRAY_BITS-1:0] arrayNum_t;                    // Array number
  typedef logic [`HEAP_INDEX_BITS-1:0] elemIndex_t;                   // Element within an array
  typedef logic [`HEAP_INDEX_BITS:0]   arraySize_t;                   // 0 up to full length
  typedef logic [`HEAP_DATA_BITS-1:0]  heapData_t;                    // One element
  typedef logic [`HEAP_ARRAY_LENGTH*`HEAP_DATA_BITS-1:0] arrayRow_t;  // Element 0 at bit 0

  // --------------------
  // Actions, one per cycle
  typedef enum logic [4:0] {
    idle     = 5'd0,  // Nothing, outputs hold
    clearAll,         // Drop every array
    write,            // Store in at index, grow size
    read,             // Element at index
    size,             // Live length of array
    push,             // Append in
    pop,              // Remove and return last
    index,            // 1-based position of last match
    less,             // Count below in
    greater,          // Count above in
    alloc,            // New array number on out
    free,             // Return array for reuse
    add,              // Element + in
    subtract,         // Element - in
    orOp,             // Element | in
    xorOp,            // Element ^ in
    andOp             // Element & in
  } heapAction_t;

  // --------------------
  // Result of each action
  typedef enum logic [2:0] {
    none,             // Success
    notAllocated,     // Array not in use
    outOfBounds,      // Index past live length
    full,             // Push onto full array
    empty,            // Pop from empty array
    outOfMemory       // No array left to hand out
  } heapError_t;

endpackage

`default_nettype wire

/* logic/heap_config.svh */
/*
  Sizing of the array heap. Included by the package and by every RTL
  module that needs array counts or widths.
*/

`ifndef HEAP_CONFIG_SVH
`define HEAP_CONFIG_SVH

// --------------------
// Heap geometry
`define HEAP_ARRAYS       4   // Arrays in the heap
`define HEAP_ARRAY_LENGTH 8   // Elements per array
`define HEAP_DATA_BITS    16  // Element width

// --------------------
// Derived widths
`define HEAP_ARRAY_BITS   2   // Array number, log2 of HEAP_ARRAYS
`define HEAP_INDEX_BITS   3   // Element index, log2 of HEAP_ARRAY_LENGTH

`endif
